/* sources.f */
+incdir+hdl
hdl/programRunnerPkg.sv
hdl/codeMemory.sv
hdl/localMemory.sv
hdl/operandResolver.sv
hdl/executeUnit.sv
hdl/sequencer.sv
hdl/programRunner.sv
tb/programRunner_asserts.sv
tb/programRunnerTb.sv

/* run.sh */
#!/bin/sh
# build and run the program runner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
  --top-module programRunnerTb --Mdir obj_dir -o simv

./obj_dir/simv > sim.log 2>&1
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0

/* tb/programRunnerTb.sv */
/*
  testbench of the program runner: clock, reset, program loader,
  output collector, directed tests, compare tasks and watchdog
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module programRunnerTb import programRunnerPkg::*; ();

  localparam int CLOCK_PERIOD    = 100;
  localparam int TEST_COUNT      = 6;
  localparam int CYCLES_PER_TEST = 200;

  logic                        clock;
  logic                        reset;
  logic                        run;
  logic                        codeWrite;
  logic [`CODE_ADDR_WIDTH-1:0] codeAddress;
  instructionWord              codeData;
  logic [`CODE_ADDR_WIDTH:0]   programLength;
  logic                        finished;
  logic                        outValid;
  word                         outData;

  int             errorCount;
  int             assertFailures;
  instructionWord codeImage[$];         // program of the current test
  word            seenOutputs[$];
  word            expectedOutputs[$];

  programRunner programRunner_inst (
    .clock, .reset, .run, .codeWrite, .codeAddress, .codeData,
    .programLength, .finished, .outValid, .outData
  );

  bind programRunner programRunnerAsserts programRunnerAsserts_inst (
    .clock, .reset, .run, .finished, .outValid
  );

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  always @(negedge clock) begin
    if (outValid === 1'b1) seenOutputs.push_back(outData);   // sampled while strobe is stable
  end

  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLOCK_PERIOD);
    $display("watchdog expired, a test hung");
    $display("tests failed");
    $finish;
  end

  // operand and instruction builders ---
  function automatic operandWord immediate(input int value);
    operandWord op;
    op = '0;
    op.fields.arena   = 2'd2;
    op.fields.address = value[15:0];
    return op;
  endfunction

  function automatic operandWord localWord(input int address, input int delta,
                                           input bit viaPointer);
    operandWord op;
    op = '0;
    op.fields.arena    = 2'd2;
    op.fields.dAddress = viaPointer ? 2'd2 : 2'd1;     // indirect or direct
    op.fields.address  = address[15:0];
    op.fields.delta    = delta[7:0];
    return op;
  endfunction

  function automatic operandWord jumpBy(input int offset);
    operandWord op;
    op = '0;
    op.jump.offset = offset;
    return op;
  endfunction

  function automatic instructionWord makeInstruction(input logic [31:0] opCode,
      input operandWord target, input operandWord source1, input operandWord source2);
    instructionWord instr;
    instr = '0;
    instr.operator = opCode;
    instr.target   = target;
    instr.source1  = source1;
    instr.source2  = source2;
    return instr;
  endfunction

  // driving and checking -------------
  task automatic stepCycles(input int count);
    repeat (count) begin
      @(posedge clock);
      #1;                                // drive after the edge
    end
  endtask

  task automatic checkWord(input string name, input word actual, input word expected);
    if (actual !== expected) begin
      $display("FAIL %0t %s actual=%0d expected=%0d", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("FAIL %0t %s actual=%b expected=%b", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic loadProgram();
    run = 1'b0;
    foreach (codeImage[i]) begin
      codeWrite   = 1'b1;
      codeAddress = `CODE_ADDR_WIDTH'(i);
      codeData    = codeImage[i];
      stepCycles(1);
    end
    codeWrite = 1'b0;
  endtask

  task automatic runProgram(input int length);
    int cycles;
    cycles = 0;
    seenOutputs.delete();
    programLength = (`CODE_ADDR_WIDTH + 1)'(length);
    run = 1'b1;
    while (finished !== 1'b1 && cycles < CYCLES_PER_TEST) begin
      stepCycles(1);
      cycles++;
    end
    if (finished !== 1'b1) begin
      $display("program of length %0d did not finish in %0d cycles", length, cycles);
      errorCount++;
    end
    stepCycles(1);
  endtask

  task automatic stopRun();
    run = 1'b0;
    stepCycles(1);
  endtask

  task automatic compareOutputs();
    checkWord("outCount", word'(seenOutputs.size()), word'(expectedOutputs.size()));
    foreach (expectedOutputs[i]) begin
      if (i < seenOutputs.size()) begin
        checkWord($sformatf("outData[%0d]", i), seenOutputs[i], expectedOutputs[i]);
      end
    end
  endtask

  task automatic clearTest();
    codeImage.delete();
    expectedOutputs.delete();
  endtask

  // directed tests ---------------
  task automatic testAddOut();
    clearTest();
    codeImage.push_back(makeInstruction(`OP_ADD, localWord(0, 0, 0), immediate(2), immediate(3)));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(0, 0, 0), '0));
    expectedOutputs.push_back(word'(5));
    loadProgram();
    runProgram(2);
    checkFlag("finished", finished, 1'b1);
    stopRun();
    compareOutputs();
  endtask

  task automatic testAddressing();
    word first;
    word pointer;
    word third;
    first   = 7;
    pointer = 1;
    third   = -4;
    clearTest();
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(1, 0, 0), immediate(first), '0));
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(2, 0, 0), immediate(pointer), '0));
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(3, 0, 0), immediate(third), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(1, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(2, 2, 1), '0));  // word 2+1
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(1, 2, 0), '0));  // word 1+2
    codeImage.push_back(makeInstruction(`OP_SUBTRACT, localWord(4, 0, 0),
                                        localWord(1, 0, 0), localWord(3, 0, 0)));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(4, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(2, 4, 1), immediate(9), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(5, 0, 0), '0));  // 4+pointer
    expectedOutputs.push_back(first);
    expectedOutputs.push_back(third);
    expectedOutputs.push_back(third);
    expectedOutputs.push_back(first - third);
    expectedOutputs.push_back(word'(9));
    loadProgram();
    runProgram(codeImage.size());
    stopRun();
    compareOutputs();
  endtask

  task automatic testNotShift();
    logic [31:0] raw;
    raw = 32'hFFFF_FFF0;
    clearTest();
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(0, 0, 0), immediate(0), '0));
    codeImage.push_back(makeInstruction(`OP_NOT, localWord(1, 0, 0), localWord(0, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(1, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(2, 0, 0), immediate(5), '0));
    codeImage.push_back(makeInstruction(`OP_NOT, localWord(3, 0, 0), localWord(2, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(3, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(4, 0, 0), immediate(-16), '0));
    codeImage.push_back(makeInstruction(`OP_SHIFT_LEFT, localWord(4, 0, 0), immediate(2), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(4, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_SHIFT_RIGHT, localWord(4, 0, 0), immediate(4), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(4, 0, 0), '0));
    expectedOutputs.push_back(word'(1));
    expectedOutputs.push_back(word'(0));
    raw = raw << 2;
    expectedOutputs.push_back(word'(raw));
    raw = raw >> 4;                      // unsigned shift fills with zeros
    expectedOutputs.push_back(word'(raw));
    loadProgram();
    runProgram(codeImage.size());
    stopRun();
    compareOutputs();
  endtask

  task automatic testJumps();
    int count;
    count = 4;
    clearTest();
    codeImage.push_back(makeInstruction(`OP_MOV, localWord(0, 0, 0), immediate(count), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(0, 0, 0), '0));
    codeImage.push_back(makeInstruction(`OP_SUBTRACT, localWord(0, 0, 0),
                                        localWord(0, 0, 0), immediate(1)));
    codeImage.push_back(makeInstruction(`OP_JNE, jumpBy(-2), localWord(0, 0, 0), immediate(0)));
    codeImage.push_back(makeInstruction(`OP_JGT, jumpBy(2), immediate(1), immediate(5)));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, immediate(100), '0));
    codeImage.push_back(makeInstruction(`OP_JMP, jumpBy(2), '0, '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, immediate(200), '0));  // jumped over
    codeImage.push_back(makeInstruction(`OP_OUT, '0, immediate(300), '0));
    for (int k = count; k > 0; k--) begin
      expectedOutputs.push_back(word'(k));
    end
    expectedOutputs.push_back(word'(100));
    expectedOutputs.push_back(word'(300));
    loadProgram();
    runProgram(codeImage.size());
    stopRun();
    compareOutputs();
  endtask

  task automatic testRestart();
    clearTest();
    codeImage.push_back(makeInstruction(`OP_OUT, '0, immediate(11), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, immediate(22), '0));
    codeImage.push_back(makeInstruction(`OP_OUT, '0, immediate(33), '0));
    expectedOutputs = '{word'(11), word'(22), word'(33)};
    loadProgram();
    runProgram(3);
    stopRun();
    checkFlag("finished", finished, 1'b0);
    compareOutputs();
    void'(expectedOutputs.pop_back());   // shorter program drops the last out
    runProgram(2);
    stopRun();
    compareOutputs();
  endtask

  task automatic testRandom();
    int  a;
    int  b;
    bit  useSubtract;
    clearTest();
    for (int k = 0; k < 20; k++) begin
      a = int'($urandom % 65536) - 32768;
      b = int'($urandom % 65536) - 32768;
      useSubtract = 1'($urandom % 2);
      codeImage.push_back(makeInstruction(useSubtract ? `OP_SUBTRACT : `OP_ADD,
                                          localWord(6, 0, 0), immediate(a), immediate(b)));
      codeImage.push_back(makeInstruction(`OP_OUT, '0, localWord(6, 0, 0), '0));
      expectedOutputs.push_back(useSubtract ? word'(a - b) : word'(a + b));
    end
    loadProgram();
    runProgram(codeImage.size());
    stopRun();
    compareOutputs();
  endtask

  // ------------------------------
  initial begin
    void'($urandom(32'h942a_4a43));
    errorCount    = 0;
    reset         = 1'b1;
    run           = 1'b0;
    codeWrite     = 1'b0;
    codeAddress   = '0;
    codeData      = '0;
    programLength = '0;
    stepCycles(5);
    reset = 1'b0;
    checkFlag("finished", finished, 1'b0);
    checkFlag("outValid", outValid, 1'b0);
    testAddOut();
    testAddressing();
    testNotShift();
    testJumps();
    testRestart();
    testRandom();
    assertFailures = programRunner_inst.programRunnerAsserts_inst.failureCount;
    $display("errors: %0d  assertion failures: %0d", errorCount, assertFailures);
    if (errorCount == 0 && assertFailures == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/programRunner_asserts.sv */
/*
  concurrent checks on the control outputs of the runner
*/
`timescale 1ns/1ps
`default_nettype none

module programRunnerAsserts (
  input wire logic clock,
  input wire logic reset,
  input wire logic run,
  input wire logic finished,
  input wire logic outValid
);

  int failureCount = 0;                   // failed assertion checks

  // strobe clear right after reset
  outValidAfterReset: assert property (@(posedge clock) reset |=> !outValid)
    else begin
      $error("outValid is high in the cycle after reset");
      failureCount++;
    end

  outValidNotWhenFinished: assert property (@(posedge clock) disable iff (reset)
    $rose(outValid) |-> !finished)
    else begin
      $error("outValid rose while finished was high");
      failureCount++;
    end

  // only a low run level rearms the runner
  finishedFallsAfterRunLow: assert property (@(posedge clock) disable iff (reset)
    $fell(finished) |-> $past(!run || reset))
    else begin
      $error("finished fell although run stayed high");
      failureCount++;
    end

endmodule

`default_nettype wire

/* hdl/programRunner.sv */
/*
  program runner top level: code store, local words,
  three operand resolvers, execute unit, sequencer
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module programRunner import programRunnerPkg::*; (
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire logic                        run,
  input  wire logic                        codeWrite,
  input  wire logic [`CODE_ADDR_WIDTH-1:0] codeAddress,
  input  wire instructionWord              codeData,
  input  wire logic [`CODE_ADDR_WIDTH:0]   programLength,
  output logic                             finished,
  output logic                             outValid,
  output word                              outData
);

  logic [`CODE_ADDR_WIDTH-1:0]  ip;
  instructionWord               instruction;
  logic [31:0]                  operator;
  word                          jumpOffset;
  localWords                    words;
  word                          source1Value;
  word                          source2Value;
  word                          targetValue;
  logic [`LOCAL_ADDR_WIDTH-1:0] targetLocation;
  logic                         targetWritable;
  logic                         executing;
  logic                         writeEnable;
  word                          writeData;
  logic                         branchTaken;

  assign operator   = instruction.operator;
  assign jumpOffset = instruction.target.jump.offset;     // target read as a jump

  codeMemory codeMemory_inst (
    .clock, .codeWrite, .codeAddress, .codeData, .ip, .instruction
  );

  localMemory localMemory_inst (
    .clock, .reset, .writeEnable,
    .writeAddress(targetLocation),
    .writeData,
    .words
  );

  // operands ---------------------
  operandResolver source1Resolver (
    .operand(instruction.source1), .words, .value(source1Value),
    .location(), .writable()
  );

  operandResolver source2Resolver (
    .operand(instruction.source2), .words, .value(source2Value),
    .location(), .writable()
  );

  operandResolver targetResolver (
    .operand(instruction.target), .words, .value(targetValue),
    .location(targetLocation), .writable(targetWritable)
  );

  executeUnit executeUnit_inst (
    .clock, .reset, .executing, .operator,
    .source1Value, .source2Value, .targetValue, .targetWritable,
    .writeEnable, .writeData, .branchTaken, .outValid, .outData
  );

  sequencer sequencer_inst (
    .clock, .reset, .run, .programLength, .branchTaken, .jumpOffset,
    .ip, .executing, .finished
  );

endmodule

`default_nettype wire

/* hdl/sequencer.sv */
/*
  instruction pointer, range check,
  program end and the finished flag
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module sequencer import programRunnerPkg::*; (
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire logic                        run,
  input  wire logic [`CODE_ADDR_WIDTH:0]   programLength,
  input  wire logic                        branchTaken,
  input  wire word                         jumpOffset,
  output logic [`CODE_ADDR_WIDTH-1:0]      ip,
  output logic                             executing,
  output logic                             finished
);

  word  pointer;                          // full width so a wild jump stays out of range
  logic inRange;

  assign inRange   = !pointer[`WORD_WIDTH-1] && pointer < word'(programLength);
  assign executing = run && inRange;
  assign ip        = pointer[`CODE_ADDR_WIDTH-1:0];

  always_ff @(posedge clock) begin
    if (reset) begin
      pointer  <= '0;
      finished <= 1'b0;
    end else if (!run) begin
      pointer  <= '0;                     // rearm for the next run
      finished <= 1'b0;
    end else if (inRange) begin
      pointer  <= branchTaken ? pointer + jumpOffset : pointer + word'(1);
    end else begin
      finished <= 1'b1;                   // held until run drops
    end
  end

endmodule

`default_nettype wire

/* hdl/executeUnit.sv */
/*
  operator decode, arithmetic, jump decision
  and the registered out strobe
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module executeUnit import programRunnerPkg::*; (
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire logic        executing,     // ip in range while running
  input  wire logic [31:0] operator,
  input  wire word         source1Value,
  input  wire word         source2Value,
  input  wire word         targetValue,
  input  wire logic        targetWritable,
  output logic             writeEnable,
  output word              writeData,
  output logic             branchTaken,
  output logic             outValid,
  output word              outData
);

  word  result;
  logic doWrite;                          // operator stores into target
  logic isOut;

  always_comb begin
    result      = '0;
    doWrite     = 1'b0;
    isOut       = 1'b0;
    branchTaken = 1'b0;
    case (operator)
      `OP_ADD: begin
        result  = source1Value + source2Value;
        doWrite = 1'b1;
      end
      `OP_SUBTRACT: begin
        result  = source1Value - source2Value;
        doWrite = 1'b1;
      end
      `OP_MOV: begin
        result  = source1Value;
        doWrite = 1'b1;
      end
      `OP_NOT: begin
        result  = source1Value == 0 ? word'(1) : word'(0);
        doWrite = 1'b1;
      end
      `OP_SHIFT_LEFT: begin
        result  = targetValue << source1Value;
        doWrite = 1'b1;
      end
      `OP_SHIFT_RIGHT: begin
        result  = word'($unsigned(targetValue) >> source1Value);  // logical, no sign fill
        doWrite = 1'b1;
      end
      `OP_OUT:    isOut = 1'b1;
      // jumps compare signed values
      `OP_JEQ:    branchTaken = source1Value == source2Value;
      `OP_JNE:    branchTaken = source1Value != source2Value;
      `OP_JLT:    branchTaken = source1Value <  source2Value;
      `OP_JLE:    branchTaken = source1Value <= source2Value;
      `OP_JGT:    branchTaken = source1Value >  source2Value;
      `OP_JGE:    branchTaken = source1Value >= source2Value;
      `OP_JTRUE:  branchTaken = source1Value != 0;
      `OP_JFALSE: branchTaken = source1Value == 0;
      `OP_JMP:    branchTaken = 1'b1;
      default:    result = '0;             // everything else is a nop
    endcase
  end

  assign writeEnable = executing && targetWritable && doWrite;
  assign writeData   = result;

  // out strobe -------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      outValid <= 1'b0;
    end else begin
      outValid <= executing && isOut;    // one cycle per out instruction
    end
  end

  always_ff @(posedge clock) begin
    if (executing && isOut) begin
      outData <= source1Value;
    end
  end

endmodule

`default_nettype wire

/* hdl/operandResolver.sv */
/*
  one operand descriptor resolved to a value,
  a local write location and a writable flag
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module operandResolver import programRunnerPkg::*; (
  input  wire operandWord                   operand,
  input  wire localWords                    words,
  output word                               value,
  output logic [`LOCAL_ADDR_WIDTH-1:0]      location,
  output logic                              writable
);

  logic [15:0]                   directSum;
  word                           indirectSum;
  logic [`LOCAL_ADDR_WIDTH-1:0]  directIndex;
  logic [`LOCAL_ADDR_WIDTH-1:0]  indirectIndex;
  logic                          isLocal;

  assign isLocal     = operand.fields.arena == 2'd2;
  assign directSum   = 16'(operand.fields.delta) + operand.fields.address;
  assign indirectSum = word'(operand.fields.delta)
                     + words[operand.fields.address[`LOCAL_ADDR_WIDTH-1:0]];
  assign directIndex   = directSum[`LOCAL_ADDR_WIDTH-1:0];     // wraps inside the arena
  assign indirectIndex = indirectSum[`LOCAL_ADDR_WIDTH-1:0];

  // value ------------------------
  always_comb begin
    value = '0;                                           // invalid arena reads as zero
    if (isLocal) begin
      case (operand.fields.dAddress)
        2'd0:    value = word'($signed(operand.fields.address));  // immediate, sign extended
        2'd1:    value = words[directIndex];
        2'd2:    value = words[indirectIndex];
        default: value = '0;
      endcase
    end
  end

  assign location = operand.fields.dAddress == 2'd2 ? indirectIndex : directIndex;
  assign writable = isLocal && (operand.fields.dAddress == 2'd1 ||
                                operand.fields.dAddress == 2'd2);

endmodule

`default_nettype wire

/* hdl/localMemory.sv */
/*
  local word registers with one write port,
  every word visible for operand resolution
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module localMemory import programRunnerPkg::*; (
  input  wire logic                         clock,
  input  wire logic                         reset,
  input  wire logic                         writeEnable,
  input  wire logic [`LOCAL_ADDR_WIDTH-1:0] writeAddress,
  input  wire word                          writeData,
  output localWords                         words
);

  always_ff @(posedge clock) begin
    if (reset) begin
      words <= '0;                                        // program state starts at zero
    end else if (writeEnable) begin
      words[writeAddress] <= writeData;
    end
  end

endmodule

`default_nettype wire

/* hdl/codeMemory.sv */
/*
  instruction store, host write port and
  combinational read at the instruction pointer
*/
`timescale 1ns/1ps
`default_nettype none
`include "programRunner_params.svh"

module codeMemory import programRunnerPkg::*; (
  input  wire logic                        clock,
  input  wire logic                        codeWrite,    // host load strobe
  input  wire logic [`CODE_ADDR_WIDTH-1:0] codeAddress,
  input  wire instructionWord              codeData,
  input  wire logic [`CODE_ADDR_WIDTH-1:0] ip,
  output instructionWord                   instruction
);

  instructionWord slots [`N_INSTRUCTIONS];                // contents undefined until loaded

  always_ff @(posedge clock) begin
    if (codeWrite) begin
      slots[codeAddress] <= codeData;
    end
  end

  assign instruction = slots[ip];                         // same cycle fetch

endmodule

`default_nettype wire

/* hdl/programRunnerPkg.sv */
/*
  machine word, local word array, operand views
  and the instruction layout
*/
`default_nettype none
`include "programRunner_params.svh"

package programRunnerPkg;

  typedef logic signed [`WORD_WIDTH-1:0] word;
  typedef word [`N_LOCAL-1:0] localWords;         // all local words side by side

  // operand as a value or location
  typedef struct packed {
    logic [31:0] area;                            // only meaningful to jumps here
    logic [15:0] address;
    logic [1:0]  unused;
    logic [1:0]  arena;                           // 0 invalid, 2 local
    logic [1:0]  dArea;                           // heap mode, ignored
    logic [1:0]  dAddress;                        // 0 imm, 1 direct, 2 indirect
    logic [7:0]  delta;
  } operandView;

  // operand as a relative jump
  typedef struct packed {
    word         offset;                          // added to ip when taken
    logic [31:0] unused;
  } jumpView;

  typedef union packed {
    operandView fields;
    jumpView    jump;
  } operandWord;

  // ------------------------------
  typedef struct packed {
    logic [31:0] operator;
    logic [31:0] unused;
    operandWord  target;
    operandWord  source1;
    operandWord  source2;
  } instructionWord;

endpackage

`default_nettype wire

/* hdl/programRunner_params.svh */
/*
  word and instruction widths, memory sizes
  and operator codes of the program runner
*/
`ifndef PROGRAM_RUNNER_PARAMS_SVH
`define PROGRAM_RUNNER_PARAMS_SVH

`define WORD_WIDTH        32       // signed machine word
`define INSTR_WIDTH       256      // one code slot
`define N_INSTRUCTIONS    64       // code slots
`define CODE_ADDR_WIDTH   6
`define N_LOCAL           16       // local words
`define LOCAL_ADDR_WIDTH  4

// operator codes ---------------
`define OP_ADD            32'd0
`define OP_JEQ            32'd23
`define OP_JFALSE         32'd24
`define OP_JGE            32'd25
`define OP_JGT            32'd26
`define OP_JLE            32'd27
`define OP_JLT            32'd28
`define OP_JNE            32'd29
`define OP_JTRUE          32'd30
`define OP_JMP            32'd31
`define OP_MOV            32'd35
`define OP_NOT            32'd38
`define OP_OUT            32'd39
`define OP_SHIFT_LEFT     32'd54
`define OP_SHIFT_RIGHT    32'd55
`define OP_SUBTRACT       32'd57

`endif
